/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing --assert --timescale 1ns/100ps -j 0
TOP       := tb_board_ctrl
FILELIST  := sources.f
BUILD_DIR := obj_dir
SIM       := $(BUILD_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell grep -v '^+' $(FILELIST)) verification/tb_wb_tasks.svh

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	@grep -q "^RESULT: PASS$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* source/board_ctrl_top.sv */
`timescale 1ns/100ps

module board_ctrl_top (
  input  logic                wb_clk_i,
  input  logic                wb_rst_i,
  input  wb_bus_pkg::wb_req_t wb_req_i,
  output wb_bus_pkg::wb_rsp_t wb_rsp_o,
  output logic                irq_o,
  output logic                user_rst_o
);

  wb_bus_pkg::wb_req_t sys_req;
  wb_bus_pkg::wb_rsp_t sys_rsp;
  wb_bus_pkg::wb_req_t sram_req;
  wb_bus_pkg::wb_rsp_t sram_rsp;
  logic                soft_reset;

  wb_slave_decode u_wb_slave_decode (
    .wb_clk_i   (wb_clk_i),
    .wb_rst_i   (wb_rst_i),
    .m_req_i    (wb_req_i),
    .m_rsp_o    (wb_rsp_o),
    .sys_req_o  (sys_req),
    .sys_rsp_i  (sys_rsp),
    .sram_req_o (sram_req),
    .sram_rsp_i (sram_rsp)
  );

  sys_block u_sys_block (
    .wb_clk_i     (wb_clk_i),
    .wb_rst_i     (wb_rst_i),
    .wb_req_i     (sys_req),
    .wb_rsp_o     (sys_rsp),
    .soft_reset_o (soft_reset),
    .user_irq_o   (irq_o)
  );

  wb_sram u_wb_sram (
    .wb_clk_i (wb_clk_i),
    .wb_rst_i (wb_rst_i),
    .wb_req_i (sram_req),
    .wb_rsp_o (sram_rsp)
  );

  reset_sequencer u_reset_sequencer (
    .wb_clk_i     (wb_clk_i),
    .wb_rst_i     (wb_rst_i),
    .soft_reset_i (soft_reset),
    .user_rst_o   (user_rst_o)
  );

endmodule

/* source/reset_sequencer.sv */
`timescale 1ns/100ps

module reset_sequencer (
  input  logic wb_clk_i,
  input  logic wb_rst_i,
  input  logic soft_reset_i,
  output logic user_rst_o
);

  localparam int CNT_W = $clog2(sys_regs_pkg::RST_HOLD_CYCLES + 1);

  typedef logic [CNT_W-1:0] hold_cnt_t;

  localparam hold_cnt_t HOLD = hold_cnt_t'(sys_regs_pkg::RST_HOLD_CYCLES);

  hold_cnt_t hold_cnt;

  // reload while any source is active, count down once all are released.
  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      hold_cnt <= HOLD;
    end else if (soft_reset_i) begin
      hold_cnt <= HOLD;
    end else if (hold_cnt != '0) begin
      hold_cnt <= hold_cnt - hold_cnt_t'(1);
    end
  end

  // sources assert at once, release is stretched by the counter.
  assign user_rst_o = wb_rst_i | soft_reset_i | (hold_cnt != '0);

endmodule

/* source/sys_block.sv */
`timescale 1ns/100ps

module sys_block (
  input  logic                wb_clk_i,
  input  logic                wb_rst_i,
  input  wb_bus_pkg::wb_req_t wb_req_i,
  output wb_bus_pkg::wb_rsp_t wb_rsp_o,
  output logic                soft_reset_o,
  output logic                user_irq_o
);

  logic                  ack_q;
  logic                  accept;
  logic                  wr_en;
  sys_regs_pkg::sys_reg_e req_idx;
  sys_regs_pkg::sys_reg_e rd_idx;
  wb_bus_pkg::wb_dat_t   scratch_pad;
  wb_bus_pkg::wb_dat_t   rd_dat;

  assign accept  = wb_req_i.cyc & wb_req_i.stb & ~ack_q; // no re-ack while ack is high.
  assign wr_en   = accept & wb_req_i.we;
  assign req_idx = sys_regs_pkg::sys_reg_e'(wb_req_i.adr[4:1]);

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      ack_q        <= 1'b0;
      soft_reset_o <= 1'b0;
      user_irq_o   <= 1'b0;
    end else begin
      ack_q <= accept;
      if (wr_en && wb_req_i.sel[0]) begin
        if (req_idx == sys_regs_pkg::REG_SOFT_RESET) begin
          soft_reset_o <= wb_req_i.dat[0];
        end
        if (req_idx == sys_regs_pkg::REG_USER_IRQ) begin
          user_irq_o <= wb_req_i.dat[0];
        end
      end
    end
  end

  always_ff @(posedge wb_clk_i) begin
    if (accept) begin
      rd_idx <= req_idx; // read data is muxed from this in the ack cycle.
    end
    if (wr_en && req_idx == sys_regs_pkg::REG_SCRATCHPAD) begin
      if (wb_req_i.sel[0]) begin
        scratch_pad[7:0] <= wb_req_i.dat[7:0];
      end
      if (wb_req_i.sel[1]) begin
        scratch_pad[15:8] <= wb_req_i.dat[15:8];
      end
    end
  end

  // read-only indices ignore writes, unused ones read as zero.
  always_comb begin
    case (rd_idx)
      sys_regs_pkg::REG_BOARD_ID:     rd_dat = sys_regs_pkg::BOARD_ID;
      sys_regs_pkg::REG_REV_MAJOR:    rd_dat = sys_regs_pkg::REV_MAJOR;
      sys_regs_pkg::REG_REV_MINOR:    rd_dat = sys_regs_pkg::REV_MINOR;
      sys_regs_pkg::REG_REV_RCS:      rd_dat = sys_regs_pkg::REV_RCS;
      sys_regs_pkg::REG_RCS_UPTODATE: rd_dat = {15'b0, sys_regs_pkg::RCS_UPTODATE};
      sys_regs_pkg::REG_SCRATCHPAD:   rd_dat = scratch_pad;
      sys_regs_pkg::REG_SOFT_RESET:   rd_dat = {15'b0, soft_reset_o};
      sys_regs_pkg::REG_USER_IRQ:     rd_dat = {15'b0, user_irq_o};
      default:                        rd_dat = '0;
    endcase
  end

  assign wb_rsp_o.ack = ack_q;
  assign wb_rsp_o.dat = rd_dat;

endmodule

/* source/sys_regs_pkg.sv */
package sys_regs_pkg;

  // register index, taken from word address bits 4:1.
  typedef enum logic [3:0] {
    REG_BOARD_ID     = 4'd0,
    REG_REV_MAJOR    = 4'd1,
    REG_REV_MINOR    = 4'd2,
    REG_REV_RCS      = 4'd3,
    REG_RCS_UPTODATE = 4'd4,
    REG_SCRATCHPAD   = 4'd5,
    REG_SOFT_RESET   = 4'd6,
    REG_USER_IRQ     = 4'd7
  } sys_reg_e;

  localparam wb_bus_pkg::wb_dat_t BOARD_ID  = 16'hdead;
  localparam wb_bus_pkg::wb_dat_t REV_MAJOR = 16'h0001;
  localparam wb_bus_pkg::wb_dat_t REV_MINOR = 16'h0004;
  localparam wb_bus_pkg::wb_dat_t REV_RCS   = 16'h3a7c;

  localparam logic RCS_UPTODATE = 1'b1; // no local changes at build time.

  // user reset stays asserted this long after all sources release.
  localparam int RST_HOLD_CYCLES = 8;

endpackage

/* source/wb_bus_pkg.sv */
package wb_bus_pkg;

  typedef logic [31:0] wb_adr_t; // byte address.
  typedef logic [15:0] wb_dat_t;
  typedef logic [1:0]  wb_sel_t; // one select per byte lane.

  typedef struct packed {
    logic    cyc;
    logic    stb;
    logic    we;
    wb_sel_t sel;
    wb_adr_t adr;
    wb_dat_t dat;
  } wb_req_t;

  typedef struct packed {
    logic    ack;
    wb_dat_t dat;
  } wb_rsp_t;

  // bit 8 picks the region, bits 31:9 must be clear.
  localparam wb_adr_t SYS_BASE  = 32'h0000_0000;
  localparam wb_adr_t SRAM_BASE = 32'h0000_0100;

  localparam int SRAM_DEPTH = 64;
  localparam int SRAM_AW    = 6; // word address bits.

endpackage

/* source/wb_slave_decode.sv */
`timescale 1ns/100ps

module wb_slave_decode (
  input  logic                wb_clk_i,
  input  logic                wb_rst_i,
  input  wb_bus_pkg::wb_req_t m_req_i,
  output wb_bus_pkg::wb_rsp_t m_rsp_o,
  output wb_bus_pkg::wb_req_t sys_req_o,
  input  wb_bus_pkg::wb_rsp_t sys_rsp_i,
  output wb_bus_pkg::wb_req_t sram_req_o,
  input  wb_bus_pkg::wb_rsp_t sram_rsp_i
);

  logic mapped;
  logic sel_sys;
  logic sel_sram;
  logic unmapped_ack;

  assign mapped   = (m_req_i.adr[31:9] == '0);
  assign sel_sys  = mapped & (m_req_i.adr[8] == wb_bus_pkg::SYS_BASE[8]);
  assign sel_sram = mapped & (m_req_i.adr[8] == wb_bus_pkg::SRAM_BASE[8]);

  always_comb begin
    sys_req_o      = m_req_i;
    sys_req_o.stb  = m_req_i.stb & sel_sys; // only the addressed slave sees stb.
    sram_req_o     = m_req_i;
    sram_req_o.stb = m_req_i.stb & sel_sram;
  end

  // terminate unmapped accesses so the master never waits forever.
  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      unmapped_ack <= 1'b0;
    end else begin
      unmapped_ack <= m_req_i.cyc & m_req_i.stb & ~mapped & ~unmapped_ack;
    end
  end

  always_comb begin
    if (sel_sys) begin
      m_rsp_o = sys_rsp_i;
    end else if (sel_sram) begin
      m_rsp_o = sram_rsp_i;
    end else begin
      m_rsp_o.ack = unmapped_ack;
      m_rsp_o.dat = '0; // unmapped reads return zero.
    end
  end

endmodule

/* source/wb_sram.sv */
`timescale 1ns/100ps

module wb_sram (
  input  logic                wb_clk_i,
  input  logic                wb_rst_i,
  input  wb_bus_pkg::wb_req_t wb_req_i,
  output wb_bus_pkg::wb_rsp_t wb_rsp_o
);

  localparam int LANES = $bits(wb_bus_pkg::wb_sel_t);

  typedef logic [wb_bus_pkg::SRAM_AW-1:0] word_adr_t;

  wb_bus_pkg::wb_dat_t mem [wb_bus_pkg::SRAM_DEPTH];
  wb_bus_pkg::wb_dat_t rd_dat;
  word_adr_t           word_adr;
  logic                ack_q;
  logic                accept;

  assign word_adr = wb_req_i.adr[wb_bus_pkg::SRAM_AW:1]; // bit 0 is the byte within a word.
  assign accept   = wb_req_i.cyc & wb_req_i.stb & ~ack_q;

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= accept;
    end
  end

  always_ff @(posedge wb_clk_i) begin
    if (accept) begin
      rd_dat <= mem[word_adr];
      if (wb_req_i.we) begin
        for (int i = 0; i < LANES; i++) begin
          if (wb_req_i.sel[i]) begin
            mem[word_adr][8*i +: 8] <= wb_req_i.dat[8*i +: 8];
          end
        end
      end
    end
  end

  assign wb_rsp_o.ack = ack_q;
  assign wb_rsp_o.dat = rd_dat;

endmodule

/* sources.f */
+incdir+verification
source/wb_bus_pkg.sv
source/sys_regs_pkg.sv
source/wb_slave_decode.sv
source/sys_block.sv
source/wb_sram.sv
source/reset_sequencer.sv
source/board_ctrl_top.sv
verification/tb_board_ctrl.sv

/* verification/tb_wb_tasks.svh */
`ifndef TB_WB_TASKS_SVH
`define TB_WB_TASKS_SVH

// xorshift32 step that advances the state on every call.
function automatic logic [31:0] next_rand();
  rng_state = rng_state ^ (rng_state << 13);
  rng_state = rng_state ^ (rng_state >> 17);
  rng_state = rng_state ^ (rng_state << 5);
  return rng_state;
endfunction

function automatic wb_bus_pkg::wb_adr_t sys_adr(input logic [3:0] idx);
  return wb_bus_pkg::SYS_BASE | {27'b0, idx, 1'b0};
endfunction

function automatic wb_bus_pkg::wb_adr_t sram_adr(input logic [5:0] word);
  return wb_bus_pkg::SRAM_BASE | {25'b0, word, 1'b0};
endfunction

// request held until ack, then stb is dropped for a cycle.
task automatic bus_transfer(input logic we, input wb_bus_pkg::wb_adr_t adr,
                            input wb_bus_pkg::wb_dat_t wdat, input wb_bus_pkg::wb_sel_t sel,
                            output wb_bus_pkg::wb_dat_t rdat);
  wb_bus_pkg::wb_req_t req;
  req     = '0;
  req.cyc = 1'b1;
  req.stb = 1'b1;
  req.we  = we;
  req.sel = sel;
  req.adr = adr;
  req.dat = wdat;
  @(posedge wb_clk_i);
  m_req <= req;
  @(negedge wb_clk_i);
  while (!m_rsp.ack) begin
    @(negedge wb_clk_i);
  end
  rdat = m_rsp.dat; // read data is valid in the ack cycle.
  @(posedge wb_clk_i);
  m_req <= '0;
endtask

task automatic bus_write(input wb_bus_pkg::wb_adr_t adr, input wb_bus_pkg::wb_dat_t dat,
                         input wb_bus_pkg::wb_sel_t sel);
  wb_bus_pkg::wb_dat_t ignored;
  bus_transfer(1'b1, adr, dat, sel, ignored);
endtask

task automatic bus_read(input wb_bus_pkg::wb_adr_t adr, output wb_bus_pkg::wb_dat_t dat);
  bus_transfer(1'b0, adr, '0, 2'b11, dat);
endtask

`endif

/* verification/tb_board_ctrl.sv */
`timescale 1ns/100ps

module tb_board_ctrl;

  localparam int MAX_CYCLES = 4000; // the tests need about 1600 cycles.
  localparam int N_RANDOM   = 64;

  logic                wb_clk_i;
  logic                wb_rst_i;
  wb_bus_pkg::wb_req_t m_req;
  wb_bus_pkg::wb_rsp_t m_rsp;
  logic                irq;
  logic                user_rst;
  logic                req_active;
  logic [31:0]         rng_state = 32'ha20c5c2d;
  int                  value_errors = 0;
  int                  proto_errors = 0;
  int                  cycles = 0;
  int                  wait_cycles = 0;
  wb_bus_pkg::wb_dat_t sram_model [wb_bus_pkg::SRAM_DEPTH];
  wb_bus_pkg::wb_dat_t scratch_model;
  logic                soft_model = 1'b0;
  logic                irq_model = 1'b0;

  board_ctrl_top u_board_ctrl_top (
    .wb_clk_i   (wb_clk_i),
    .wb_rst_i   (wb_rst_i),
    .wb_req_i   (m_req),
    .wb_rsp_o   (m_rsp),
    .irq_o      (irq),
    .user_rst_o (user_rst)
  );

  `include "tb_wb_tasks.svh"

  assign req_active = m_req.cyc & m_req.stb;

  initial begin
    wb_clk_i = 1'b0;
    forever #20 wb_clk_i = ~wb_clk_i;
  end

  always @(posedge wb_clk_i) begin
    cycles <= cycles + 1;
    if (wb_rst_i || !req_active || m_rsp.ack) begin
      wait_cycles <= 0;
    end else begin
      wait_cycles <= wait_cycles + 1;
    end
    if (cycles == MAX_CYCLES) begin
      $display("timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  ack_one_cycle: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    m_rsp.ack |=> !m_rsp.ack)
    else begin
      proto_errors++;
      $display("[ERROR] %0d ns wb_rsp.ack expected 0 got 1", $time);
    end

  ack_latency: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    $rose(req_active) |=> m_rsp.ack)
    else begin
      proto_errors++;
      $display("[ERROR] %0d ns wb_rsp.ack expected 1 got 0", $time);
    end

  bus_alive: assert property (@(posedge wb_clk_i) wait_cycles < 4)
    else begin
      proto_errors++;
      $display("hung bus at %0d ns: request got no ack within 4 cycles", $time);
    end

  task automatic check_value(input string name, input wb_bus_pkg::wb_dat_t exp,
                             input wb_bus_pkg::wb_dat_t act);
    assert (act === exp)
      else begin
        value_errors++;
        $display("[ERROR] %0d ns %s expected %h got %h", $time, name, exp, act);
      end
  endtask

  function automatic wb_bus_pkg::wb_dat_t merge_lanes(input wb_bus_pkg::wb_dat_t old_dat,
      input wb_bus_pkg::wb_dat_t new_dat, input wb_bus_pkg::wb_sel_t sel);
    return {sel[1] ? new_dat[15:8] : old_dat[15:8], sel[0] ? new_dat[7:0] : old_dat[7:0]};
  endfunction

  function automatic wb_bus_pkg::wb_dat_t sys_expect(input logic [3:0] idx);
    case (idx)
      4'd0:    return sys_regs_pkg::BOARD_ID;
      4'd1:    return sys_regs_pkg::REV_MAJOR;
      4'd2:    return sys_regs_pkg::REV_MINOR;
      4'd3:    return sys_regs_pkg::REV_RCS;
      4'd4:    return {15'b0, sys_regs_pkg::RCS_UPTODATE};
      4'd5:    return scratch_model;
      4'd6:    return {15'b0, soft_model};
      4'd7:    return {15'b0, irq_model};
      default: return '0;
    endcase
  endfunction

  task automatic check_sys(input logic [3:0] idx);
    wb_bus_pkg::wb_dat_t rd;
    bus_read(sys_adr(idx), rd);
    check_value($sformatf("wb_rsp.dat sys[%0d]", idx), sys_expect(idx), rd);
  endtask

  task automatic check_sram(input logic [5:0] word);
    wb_bus_pkg::wb_dat_t rd;
    bus_read(sram_adr(word), rd);
    check_value($sformatf("wb_rsp.dat sram[%0d]", word), sram_model[word], rd);
  endtask

  // counts the falling edges that still see user_rst_o high.
  task automatic count_rst_hold(output int n);
    n = 0;
    @(negedge wb_clk_i);
    while (user_rst && n < 32) begin
      n++;
      @(negedge wb_clk_i);
    end
  endtask

  initial begin
    logic [31:0]         rnd;
    wb_bus_pkg::wb_adr_t adr;
    wb_bus_pkg::wb_dat_t rd;
    int                  hold;
    m_req    <= '0;
    wb_rst_i <= 1'b1;
    repeat (3) @(posedge wb_clk_i);
    wb_rst_i <= 1'b0;
    count_rst_hold(hold);
    check_value("user_rst_o hold after wb_rst_i", 16'(sys_regs_pkg::RST_HOLD_CYCLES), 16'(hold));
    check_value("wb_rsp.ack", '0, {15'b0, m_rsp.ack});
    check_value("irq_o", '0, {15'b0, irq});

    for (int i = 0; i < 16; i++) begin
      if (i != 5) begin
        check_sys(i[3:0]);
      end
      if (i < 5) begin
        rnd = next_rand();
        bus_write(sys_adr(i[3:0]), rnd[15:0], 2'b11); // a read-only register keeps its value.
        check_sys(i[3:0]);
      end
    end

    bus_write(sys_adr(4'd7), 16'h0001, 2'b01);
    irq_model = 1'b1;
    @(negedge wb_clk_i);
    check_value("irq_o", {15'b0, irq_model}, {15'b0, irq});
    bus_write(sys_adr(4'd7), 16'h0000, 2'b10);
    @(negedge wb_clk_i);
    check_value("irq_o", {15'b0, irq_model}, {15'b0, irq});
    check_sys(4'd7);
    bus_write(sys_adr(4'd7), 16'h0000, 2'b01);
    irq_model = 1'b0;
    @(negedge wb_clk_i);
    check_value("irq_o", {15'b0, irq_model}, {15'b0, irq});
    check_sys(4'd7);

    rnd = next_rand();
    bus_write(sys_adr(4'd5), rnd[15:0], 2'b11);
    scratch_model = rnd[15:0];
    for (int n = 0; n < N_RANDOM; n++) begin
      rnd = next_rand();
      bus_write(sys_adr(4'd5), rnd[15:0], rnd[17:16]);
      scratch_model = merge_lanes(scratch_model, rnd[15:0], rnd[17:16]);
      check_sys(4'd5);
    end

    for (int w = 0; w < wb_bus_pkg::SRAM_DEPTH; w++) begin
      rnd = next_rand();
      bus_write(sram_adr(w[5:0]), rnd[15:0], 2'b11);
      sram_model[w] = rnd[15:0];
    end
    for (int n = 0; n < 3 * N_RANDOM; n++) begin
      rnd = next_rand();
      bus_write(sram_adr(rnd[21:16]), rnd[15:0], rnd[23:22]);
      sram_model[rnd[21:16]] = merge_lanes(sram_model[rnd[21:16]], rnd[15:0], rnd[23:22]);
    end
    for (int w = 0; w < wb_bus_pkg::SRAM_DEPTH; w++) begin
      check_sram(w[5:0]);
    end
    for (int i = 5; i < 8; i++) begin
      check_sys(i[3:0]); // sram words with the same low bits.
    end

    for (int n = 0; n < 8; n++) begin
      adr = next_rand();
      rnd = next_rand();
      adr = adr | (32'h200 << (rnd[20:16] % 5'd23)); // at least one of bits 31:9.
      bus_write(adr, rnd[15:0], 2'b11);
      bus_read(adr, rd);
      check_value($sformatf("wb_rsp.dat @%h", adr), '0, rd);
      check_sys(adr[4:1]);
      check_sram(adr[6:1]);
    end

    @(negedge wb_clk_i);
    check_value("user_rst_o", '0, {15'b0, user_rst});
    bus_write(sys_adr(4'd6), 16'h0001, 2'b01);
    soft_model = 1'b1;
    @(negedge wb_clk_i);
    check_value("user_rst_o", 16'd1, {15'b0, user_rst});
    check_sys(4'd6);
    bus_write(sys_adr(4'd6), 16'h0000, 2'b01);
    soft_model = 1'b0;
    count_rst_hold(hold);
    // the ack cycle is the first held one and passes inside bus_write.
    check_value("user_rst_o hold after soft reset", 16'(sys_regs_pkg::RST_HOLD_CYCLES),
                16'(hold + 1));

    $display("errors: %0d value, %0d protocol", value_errors, proto_errors);
    if (value_errors == 0 && proto_errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule
